// ==== source/fft_defines.svh ====
/*
 * Transform size, sample and twiddle widths, APB register map
 */
`ifndef FFT_DEFINES_SVH
`define FFT_DEFINES_SVH

// Points per frame and number of radix-2 stages
`define FFT_N      8
`define FFT_LOG2N  3

// Signed width of each sample component
`define FFT_DW     16

// Signed twiddle width, Q1.14 so 14 fraction bits
`define FFT_TW     16

// APB register offsets
`define FFT_REG_CTRL    4'h0
`define FFT_REG_STATUS  4'h4

`endif

// ==== source/fft_pkg.sv ====
/*
 * Complex sample type and sequencer states
 */
`include "fft_defines.svh"

package fft_pkg;

	// Complex sample, real part in the upper half
	typedef struct packed {
		logic signed [`FFT_DW-1:0] re;
		logic signed [`FFT_DW-1:0] im;
	} cplx_t;

	// Sequencer phases of one frame
	typedef enum logic [2:0] {
		IDLE,
		SINK,
		STAGE_RD,
		STAGE_DRAIN,
		SOURCE
	} seq_state_t;

endpackage

// ==== source/fft_bfly_if.sv ====
/*
 * Butterfly request and result bundle with its two modports
 */
`timescale 1ns/1ps
`include "fft_defines.svh"

interface fft_bfly_if;
	// Request side from the sequencer
	logic                  req_valid;
	fft_pkg::cplx_t        a;
	fft_pkg::cplx_t        b;
	logic [`FFT_LOG2N-1:0] tw_idx;
	logic                  scale;
	logic [`FFT_LOG2N-1:0] addr_a;
	logic [`FFT_LOG2N-1:0] addr_b;
	// Result side, two cycles after the request
	logic                  res_valid;
	fft_pkg::cplx_t        x;
	fft_pkg::cplx_t        y;
	logic [`FFT_LOG2N-1:0] wr_addr_a;
	logic [`FFT_LOG2N-1:0] wr_addr_b;

	modport seq (output req_valid, a, b, tw_idx, scale, addr_a, addr_b,
		input res_valid, x, y, wr_addr_a, wr_addr_b);
	modport core (input req_valid, a, b, tw_idx, scale, addr_a, addr_b,
		output res_valid, x, y, wr_addr_a, wr_addr_b);
endinterface

// ==== source/fft_apb_regs.sv ====
/*
 * APB slave with CTRL (enable, stage scaling) and STATUS (busy, frame count)
 */
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_apb_regs (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	input  logic        busy,
	input  logic        frame_done,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        enable,
	output logic [2:0]  scale_mask
);
	logic       access;
	logic       hit_ctrl;
	logic       hit_status;
	logic [7:0] frame_cnt;

	// Access phase and address decode
	assign access     = psel && penable;
	assign hit_ctrl   = (paddr == `FFT_REG_CTRL);
	assign hit_status = (paddr == `FFT_REG_STATUS);

	// Zero wait states
	assign pready  = 1'b1;
	// Unmapped offset errors only in its own access phase
	assign pslverr = access && !hit_ctrl && !hit_status;

	// CTRL
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			enable     <= 1'b0;
			scale_mask <= '0;
		end else if (access && pwrite && hit_ctrl) begin
			enable     <= pwdata[0];
			scale_mask <= pwdata[3:1];
		end
	end

	// Completed frames, wraps at 256
	always_ff @(posedge clk) begin
		if (!rst_n)
			frame_cnt <= '0;
		else if (frame_done)
			frame_cnt <= frame_cnt + 8'd1;
	end

	// Read mux
	always_comb begin
		prdata = '0;
		if (hit_ctrl)
			prdata[3:0] = {scale_mask, enable};
		else if (hit_status)
			prdata[15:0] = {frame_cnt, 7'd0, busy};
	end

	// Access phase must follow a setup phase of the same transfer
	a_apb_setup: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(penable) |-> psel && $past(psel));
endmodule

// ==== source/fft_sink.sv ====
/*
 * Input stream capture with bit-reversed sample RAM addressing
 */
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_sink (
	input  logic                      clk,
	input  logic                      rst_n,
	input  fft_pkg::seq_state_t       state,
	input  logic                      enable,
	input  logic                      in_valid,
	input  logic                      in_sop,
	input  logic signed [`FFT_DW-1:0] in_re,
	input  logic signed [`FFT_DW-1:0] in_im,
	output logic                      in_ready,
	output logic                      wr_en,
	output logic [`FFT_LOG2N-1:0]     wr_addr,
	output fft_pkg::cplx_t            wr_data,
	output logic                      frame_start,
	output logic                      frame_full
);
	logic                  take;
	logic                  in_sink;
	logic [`FFT_LOG2N-1:0] cnt;
	logic [`FFT_LOG2N-1:0] idx;

	assign in_sink  = (state == fft_pkg::SINK);
	// Ready while waiting for sop or filling a frame
	assign in_ready = in_sink || (state == fft_pkg::IDLE && enable);
	assign take     = in_valid && in_ready;

	// Sop sample taken in IDLE opens the frame, others there are dropped
	assign frame_start = take && in_sop && (state == fft_pkg::IDLE);
	assign frame_full  = take && in_sink && (cnt == `FFT_LOG2N'(`FFT_N - 1));

	// Index of the next sample in the frame
	always_ff @(posedge clk) begin
		if (!rst_n)
			cnt <= '0;
		else if (frame_start)
			cnt <= `FFT_LOG2N'(1);
		else if (take && in_sink)
			cnt <= cnt + 1'b1;
	end

	// Sop sample always lands in entry 0
	assign idx     = frame_start ? '0 : cnt;
	// Bit reversal for the 3-bit address
	assign wr_addr = {idx[0], idx[1], idx[2]};
	assign wr_en   = frame_start || (take && in_sink);
	assign wr_data = '{re: in_re, im: in_im};
endmodule

// ==== source/fft_engine.sv ====
/*
 * Frame sequencer FSM, in-place sample RAM, stage and butterfly addressing
 */
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_engine (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`FFT_LOG2N-1:0] scale_mask,
	input  logic                  sink_wr_en,
	input  logic [`FFT_LOG2N-1:0] sink_wr_addr,
	input  fft_pkg::cplx_t        sink_wr_data,
	input  logic                  frame_start,
	input  logic                  frame_full,
	input  logic [`FFT_LOG2N-1:0] src_rd_addr,
	input  logic                  src_done,
	output fft_pkg::seq_state_t   state,
	output fft_pkg::cplx_t        src_rd_data,
	output logic                  busy,
	output logic                  frame_done,
	fft_bfly_if.seq               bfly
);
	fft_pkg::cplx_t        ram [`FFT_N];
	// Current stage and butterfly within it
	logic [1:0]            stage;
	logic [1:0]            bf;
	// Second drain cycle
	logic                  drain;
	logic [`FFT_LOG2N-1:0] rd_a;
	logic [`FFT_LOG2N-1:0] rd_b;

	// --------------------
	// Sequencer
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= fft_pkg::IDLE;
			stage <= '0;
			bf    <= '0;
			drain <= 1'b0;
		end else begin
			case (state)
				fft_pkg::IDLE:
					if (frame_start)
						state <= fft_pkg::SINK;
				fft_pkg::SINK:
					if (frame_full)
						state <= fft_pkg::STAGE_RD;
				// One butterfly issued per cycle, four per stage
				fft_pkg::STAGE_RD: begin
					bf <= bf + 2'd1;
					if (bf == 2'd3)
						state <= fft_pkg::STAGE_DRAIN;
				end
				// Two cycles so the last results land before the next reads
				fft_pkg::STAGE_DRAIN: begin
					drain <= ~drain;
					if (drain) begin
						if (stage == 2'(`FFT_LOG2N - 1)) begin
							stage <= '0;
							state <= fft_pkg::SOURCE;
						end else begin
							stage <= stage + 2'd1;
							state <= fft_pkg::STAGE_RD;
						end
					end
				end
				fft_pkg::SOURCE:
					if (src_done)
						state <= fft_pkg::IDLE;
				default:
					state <= fft_pkg::IDLE;
			endcase
		end
	end

	assign busy       = (state != fft_pkg::IDLE);
	assign frame_done = (state == fft_pkg::SOURCE) && src_done;

	// --------------------
	// Butterfly addressing
	// --------------------
	// Pair span doubles each stage, twiddle step halves
	always_comb begin
		case (stage)
			2'd0: begin
				rd_a        = {bf, 1'b0};
				rd_b        = {bf, 1'b1};
				bfly.tw_idx = '0;
			end
			2'd1: begin
				rd_a        = {bf[1], 1'b0, bf[0]};
				rd_b        = {bf[1], 1'b1, bf[0]};
				bfly.tw_idx = {1'b0, bf[0], 1'b0};
			end
			default: begin
				rd_a        = {1'b0, bf};
				rd_b        = {1'b1, bf};
				bfly.tw_idx = {1'b0, bf};
			end
		endcase
	end

	assign bfly.req_valid = (state == fft_pkg::STAGE_RD);
	assign bfly.a         = ram[rd_a];
	assign bfly.b         = ram[rd_b];
	assign bfly.addr_a    = rd_a;
	assign bfly.addr_b    = rd_b;
	assign bfly.scale     = scale_mask[stage];

	// --------------------
	// Sample RAM
	// --------------------
	// Sink writes while capturing, butterfly pairs written back in place
	always_ff @(posedge clk) begin
		if (sink_wr_en)
			ram[sink_wr_addr] <= sink_wr_data;
		if (bfly.res_valid) begin
			ram[bfly.wr_addr_a] <= bfly.x;
			ram[bfly.wr_addr_b] <= bfly.y;
		end
	end

	// Asynchronous read for the output side
	assign src_rd_data = ram[src_rd_addr];

	// Sink writes only during capture, sop sample included
	a_sink_wr: assert property (@(posedge clk) disable iff (!rst_n)
		sink_wr_en |-> (state == fft_pkg::SINK) ||
			(state == fft_pkg::IDLE && frame_start));

	// Returning results never collide with each other or with the sink
	a_wr_unique: assert property (@(posedge clk) disable iff (!rst_n)
		bfly.res_valid |-> !sink_wr_en && (bfly.wr_addr_a != bfly.wr_addr_b));
endmodule

// ==== source/fft_bfly.sv ====
/*
 * Two-stage radix-2 butterfly with Q1.14 twiddle table and optional halving
 */
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_bfly (
	input logic      clk,
	input logic      rst_n,
	fft_bfly_if.core bfly
);
	logic signed [`FFT_TW-1:0]         w_re;
	logic signed [`FFT_TW-1:0]         w_im;
	// Full complex product terms
	logic signed [`FFT_DW+`FFT_TW:0]   p_re;
	logic signed [`FFT_DW+`FFT_TW:0]   p_im;
	// Stage one
	logic                              s1_valid;
	logic                              s1_scale;
	fft_pkg::cplx_t                    s1_a;
	logic signed [`FFT_DW+1:0]         s1_wb_re;
	logic signed [`FFT_DW+1:0]         s1_wb_im;
	logic [`FFT_LOG2N-1:0]             s1_addr_a;
	logic [`FFT_LOG2N-1:0]             s1_addr_b;
	// Stage two sums, two guard bits
	logic signed [`FFT_DW+2:0]         sum_re;
	logic signed [`FFT_DW+2:0]         sum_im;
	logic signed [`FFT_DW+2:0]         dif_re;
	logic signed [`FFT_DW+2:0]         dif_im;

	// Optional divide by two, then back to sample width
	function automatic logic signed [`FFT_DW-1:0] fit(input logic signed [`FFT_DW+2:0] v,
		input logic half);
		logic signed [`FFT_DW+2:0] t;
		t = half ? (v >>> 1) : v;
		return t[`FFT_DW-1:0];
	endfunction

	// W = exp(-j*2*pi*k/8)
	always_comb begin
		case (bfly.tw_idx[1:0])
			2'd0:    {w_re, w_im} = {`FFT_TW'(16384), `FFT_TW'(0)};
			2'd1:    {w_re, w_im} = {`FFT_TW'(11585), `FFT_TW'(-11585)};
			2'd2:    {w_re, w_im} = {`FFT_TW'(0), `FFT_TW'(-16384)};
			default: {w_re, w_im} = {`FFT_TW'(-11585), `FFT_TW'(-11585)};
		endcase
	end

	assign p_re = $signed(bfly.b.re) * w_re - $signed(bfly.b.im) * w_im;
	assign p_im = $signed(bfly.b.re) * w_im + $signed(bfly.b.im) * w_re;

	assign sum_re = $signed(s1_a.re) + s1_wb_re;
	assign sum_im = $signed(s1_a.im) + s1_wb_im;
	assign dif_re = $signed(s1_a.re) - s1_wb_re;
	assign dif_im = $signed(s1_a.im) - s1_wb_im;

	// Valid pipe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid       <= 1'b0;
			bfly.res_valid <= 1'b0;
		end else begin
			s1_valid       <= bfly.req_valid;
			bfly.res_valid <= s1_valid;
		end
	end

	// Data pipe, product truncated by 14 fraction bits
	always_ff @(posedge clk) begin
		s1_a           <= bfly.a;
		s1_wb_re       <= p_re[`FFT_TW-2 +: `FFT_DW+2];
		s1_wb_im       <= p_im[`FFT_TW-2 +: `FFT_DW+2];
		s1_scale       <= bfly.scale;
		s1_addr_a      <= bfly.addr_a;
		s1_addr_b      <= bfly.addr_b;
		bfly.x         <= '{re: fit(sum_re, s1_scale), im: fit(sum_im, s1_scale)};
		bfly.y         <= '{re: fit(dif_re, s1_scale), im: fit(dif_im, s1_scale)};
		bfly.wr_addr_a <= s1_addr_a;
		bfly.wr_addr_b <= s1_addr_b;
	end

	// Sequencer only asks for the lower half of the circle
	a_tw_range: assert property (@(posedge clk) disable iff (!rst_n)
		bfly.req_valid |-> bfly.tw_idx < `FFT_LOG2N'(`FFT_N / 2));
endmodule

// ==== source/fft_source.sv ====
/*
 * Natural-order bin readout with sop/eop and back-pressure
 */
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_source (
	input  logic                      clk,
	input  logic                      rst_n,
	input  fft_pkg::seq_state_t       state,
	input  fft_pkg::cplx_t            src_rd_data,
	input  logic                      out_ready,
	output logic [`FFT_LOG2N-1:0]     src_rd_addr,
	output logic                      src_done,
	output logic                      out_valid,
	output logic                      out_sop,
	output logic                      out_eop,
	output logic signed [`FFT_DW-1:0] out_re,
	output logic signed [`FFT_DW-1:0] out_im
);
	// Read address set up, output register may load
	logic armed;
	// Last bin already loaded
	logic all_read;
	logic load;
	logic last_addr;

	assign last_addr = (src_rd_addr == `FFT_LOG2N'(`FFT_N - 1));
	// Load when the output register is empty or being drained
	assign load      = armed && !all_read && (!out_valid || out_ready);
	assign src_done  = out_valid && out_ready && out_eop;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			armed       <= 1'b0;
			all_read    <= 1'b0;
			out_valid   <= 1'b0;
			out_sop     <= 1'b0;
			out_eop     <= 1'b0;
			src_rd_addr <= '0;
		end else if (state != fft_pkg::SOURCE) begin
			armed    <= 1'b0;
			all_read <= 1'b0;
		end else if (!armed) begin
			// Read setup cycle
			armed       <= 1'b1;
			src_rd_addr <= '0;
		end else if (load) begin
			out_valid   <= 1'b1;
			out_sop     <= (src_rd_addr == '0);
			out_eop     <= last_addr;
			all_read    <= last_addr;
			src_rd_addr <= src_rd_addr + 1'b1;
		end else if (out_valid && out_ready) begin
			out_valid <= 1'b0;
			out_sop   <= 1'b0;
			out_eop   <= 1'b0;
		end
	end

	// Bin held while out_ready is low
	always_ff @(posedge clk) begin
		if (load) begin
			out_re <= src_rd_data.re;
			out_im <= src_rd_data.im;
		end
	end
endmodule

// ==== source/fft_top.sv ====
/*
 * Top level of the FFT memory and sequencing subsystem
 */
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_top (
	input  logic                      clk,
	input  logic                      rst_n,
	// APB
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [3:0]                paddr,
	input  logic [31:0]               pwdata,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	// Input stream
	input  logic                      in_valid,
	output logic                      in_ready,
	input  logic                      in_sop,
	input  logic signed [`FFT_DW-1:0] in_re,
	input  logic signed [`FFT_DW-1:0] in_im,
	// Output stream
	output logic                      out_valid,
	input  logic                      out_ready,
	output logic                      out_sop,
	output logic                      out_eop,
	output logic signed [`FFT_DW-1:0] out_re,
	output logic signed [`FFT_DW-1:0] out_im
);
	logic                  enable;
	logic [2:0]            scale_mask;
	logic                  busy;
	logic                  frame_done;
	fft_pkg::seq_state_t   state;
	// Sink write port
	logic                  sink_wr_en;
	logic [`FFT_LOG2N-1:0] sink_wr_addr;
	fft_pkg::cplx_t        sink_wr_data;
	logic                  frame_start;
	logic                  frame_full;
	// Source read port
	logic [`FFT_LOG2N-1:0] src_rd_addr;
	fft_pkg::cplx_t        src_rd_data;
	logic                  src_done;

	fft_bfly_if bfly_bus ();

	fft_apb_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.busy(busy), .frame_done(frame_done),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.enable(enable), .scale_mask(scale_mask)
	);

	fft_sink u_sink (
		.clk(clk), .rst_n(rst_n), .state(state), .enable(enable),
		.in_valid(in_valid), .in_sop(in_sop), .in_re(in_re), .in_im(in_im),
		.in_ready(in_ready), .wr_en(sink_wr_en), .wr_addr(sink_wr_addr),
		.wr_data(sink_wr_data), .frame_start(frame_start), .frame_full(frame_full)
	);

	fft_engine u_engine (
		.clk(clk), .rst_n(rst_n), .scale_mask(scale_mask),
		.sink_wr_en(sink_wr_en), .sink_wr_addr(sink_wr_addr), .sink_wr_data(sink_wr_data),
		.frame_start(frame_start), .frame_full(frame_full),
		.src_rd_addr(src_rd_addr), .src_done(src_done),
		.state(state), .src_rd_data(src_rd_data), .busy(busy), .frame_done(frame_done),
		.bfly(bfly_bus.seq)
	);

	fft_bfly u_bfly (
		.clk(clk), .rst_n(rst_n), .bfly(bfly_bus.core)
	);

	fft_source u_source (
		.clk(clk), .rst_n(rst_n), .state(state), .src_rd_data(src_rd_data),
		.out_ready(out_ready), .src_rd_addr(src_rd_addr), .src_done(src_done),
		.out_valid(out_valid), .out_sop(out_sop), .out_eop(out_eop),
		.out_re(out_re), .out_im(out_im)
	);
endmodule

// ==== tests/fft_tb.sv ====
/*
 * Testbench for fft_top: APB and stream drivers, output collector,
 * floating-point DFT reference, directed tests and watchdog
 */
`timescale 1ns/1ps
`include "fft_defines.svh"

module fft_tb;
	localparam int unsigned SEED = 99536;
	localparam int CLK_HALF      = 2;
	localparam int RESET_CYCLES  = 16;
	// Frame completion to first out_valid
	localparam int LATENCY       = 20;
	localparam int TOL           = 4;
	localparam int FRAME_WAIT    = 200;
	localparam int NUM_FRAMES    = 8;
	localparam int FRAME_CYCLES  = 60;
	localparam int MARGIN_CYCLES = 300;
	localparam int WATCHDOG_NS   =
		(RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES + MARGIN_CYCLES) * 2 * CLK_HALF;
	localparam real PI           = 3.14159265358979;

	logic                      clk = 1'b0;
	logic                      rst_n;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [3:0]                paddr;
	logic [31:0]               pwdata;
	logic [31:0]               prdata;
	logic                      pready;
	logic                      pslverr;
	logic                      in_valid;
	logic                      in_ready;
	logic                      in_sop;
	logic signed [`FFT_DW-1:0] in_re;
	logic signed [`FFT_DW-1:0] in_im;
	logic                      out_valid;
	logic                      out_ready;
	logic                      out_sop;
	logic                      out_eop;
	logic signed [`FFT_DW-1:0] out_re;
	logic signed [`FFT_DW-1:0] out_im;

	// Bookkeeping
	string       cur_test = "reset";
	int          cyc = 0;
	int          errors = 0;
	int          checks = 0;
	int          flag_errors = 0;
	int          flag_checks = 0;
	int          frames_sent = 0;
	int          frames_out = 0;
	int          bin_idx = 0;
	bit          first_seen = 1'b0;
	int          first_valid_cyc = 0;
	int          got_rd = 0;
	int unsigned stim_state = SEED;
	int unsigned bp_state = SEED;
	logic        bp_en;
	logic        bp_bit;
	// Bin left waiting by back-pressure on the last edge
	bit          stalled = 1'b0;
	int          stall_re = 0;
	int          stall_im = 0;
	// Current frame and expected / received bins
	int          fr_re [`FFT_N];
	int          fr_im [`FFT_N];
	real         exp_re [$];
	real         exp_im [$];
	int          got_re [$];
	int          got_im [$];
	// Cycle of each output frame's eop transfer
	int          eop_cycs [$];

	fft_top dut (
		.clk(clk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.in_valid(in_valid), .in_ready(in_ready), .in_sop(in_sop),
		.in_re(in_re), .in_im(in_im),
		.out_valid(out_valid), .out_ready(out_ready), .out_sop(out_sop),
		.out_eop(out_eop), .out_re(out_re), .out_im(out_im)
	);

	always #CLK_HALF clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// --------------------
	// Random helpers
	// --------------------
	function automatic int unsigned lcg_step(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic int unsigned draw_bits();
		stim_state = lcg_step(stim_state);
		return stim_state >> 16;
	endfunction

	// Uniform in -2000..2000
	function automatic int draw_sample();
		return int'(draw_bits() % 32'd4001) - 2000;
	endfunction

	// Receiver stalls about a quarter of the cycles when enabled
	always @(posedge clk) begin
		bp_state = lcg_step(bp_state);
		bp_bit <= (bp_state[17:16] != 2'b00);
	end
	assign out_ready = !bp_en || bp_bit;

	// --------------------
	// Output collector
	// --------------------
	always @(posedge clk) begin
		if (rst_n) begin
			// Held bin must still be offered, unchanged
			if (stalled) begin
				flag_checks++;
				if (!out_valid) begin
					flag_errors++;
					$display("%s: out_valid dropped while bin %0d was held",
						cur_test, bin_idx);
				end else if (int'(out_re) != stall_re || int'(out_im) != stall_im) begin
					flag_errors++;
					$display("[ERROR] %s: held bin %0d expected %0d/%0d actual %0d/%0d",
						cur_test, bin_idx, stall_re, stall_im, out_re, out_im);
				end
			end
			stalled  = out_valid && !out_ready;
			stall_re = int'(out_re);
			stall_im = int'(out_im);
			// First out_valid of a frame, for the latency check
			if (out_valid && !first_seen) begin
				first_seen = 1'b1;
				first_valid_cyc = cyc;
			end
			if (out_valid && out_ready) begin
				flag_checks = flag_checks + 2;
				if (out_sop != (bin_idx == 0)) begin
					flag_errors++;
					$display("[ERROR] %s: bin %0d out_sop expected %0b actual %0b",
						cur_test, bin_idx, bin_idx == 0, out_sop);
				end
				if (out_eop != (bin_idx == `FFT_N - 1)) begin
					flag_errors++;
					$display("[ERROR] %s: bin %0d out_eop expected %0b actual %0b",
						cur_test, bin_idx, bin_idx == `FFT_N - 1, out_eop);
				end
				got_re.push_back(int'(out_re));
				got_im.push_back(int'(out_im));
				if (bin_idx == `FFT_N - 1) begin
					bin_idx = 0;
					frames_out++;
					first_seen = 1'b0;
					eop_cycs.push_back(cyc);
				end else begin
					bin_idx++;
				end
			end
		end
	end

	// --------------------
	// Checks and reference
	// --------------------
	task automatic expect_equal(input string what, input int expv, input int actv);
		checks++;
		if (actv != expv) begin
			errors++;
			$display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", cur_test, what, expv, actv);
		end
	endtask

	task automatic compare_close(input string what, input real expv, input int actv,
		input int tol);
		real d;
		checks++;
		d = real'(actv) - expv;
		if (d > real'(tol) || d < -real'(tol)) begin
			errors++;
			$display("[ERROR] %s: %s expected %0.2f actual %0d", cur_test, what, expv, actv);
		end
	endtask

	// DFT of the current frame, halved once per set scale bit
	task automatic push_reference(input logic [2:0] mask);
		real acc_re;
		real acc_im;
		real ang;
		real div;
		int  s;
		int  k;
		int  n;
		div = 1.0;
		for (s = 0; s < 3; s++)
			if (mask[s])
				div = div * 2.0;
		for (k = 0; k < `FFT_N; k++) begin
			acc_re = 0.0;
			acc_im = 0.0;
			for (n = 0; n < `FFT_N; n++) begin
				ang = 2.0 * PI * real'(n * k) / real'(`FFT_N);
				acc_re = acc_re + real'(fr_re[n]) * $cos(ang) + real'(fr_im[n]) * $sin(ang);
				acc_im = acc_im + real'(fr_im[n]) * $cos(ang) - real'(fr_re[n]) * $sin(ang);
			end
			exp_re.push_back(acc_re / div);
			exp_im.push_back(acc_im / div);
		end
	endtask

	// All pending expected bins against received ones, in order
	task automatic compare_bins(input int tol);
		int k;
		k = 0;
		while (exp_re.size() > 0) begin
			if (got_rd >= got_re.size()) begin
				errors++;
				$display("%s: %0d expected bins never arrived", cur_test, exp_re.size());
				exp_re.delete();
				exp_im.delete();
			end else begin
				compare_close($sformatf("bin %0d re", k), exp_re.pop_front(), got_re[got_rd], tol);
				compare_close($sformatf("bin %0d im", k), exp_im.pop_front(), got_im[got_rd], tol);
				got_rd++;
				k = (k + 1) % `FFT_N;
			end
		end
	endtask

	// --------------------
	// Bus and stream drivers
	// --------------------
	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		while (!pready)
			@(posedge clk);
		err = pslverr;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		while (!pready)
			@(posedge clk);
		data = prdata;
		err  = pslverr;
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic set_ctrl(input logic [2:0] mask);
		logic err;
		apb_write(`FFT_REG_CTRL, {28'd0, mask, 1'b1}, err);
	endtask

	// Current frame out, sample held until taken, optional valid gaps
	task automatic send_frame(input bit gaps, output int sop_cyc, output int full_cyc);
		int i;
		i = 0;
		sop_cyc = -1;
		full_cyc = -1;
		while (i < `FFT_N) begin
			if (gaps && (draw_bits() % 4 == 0)) begin
				in_valid <= 1'b0;
			end else begin
				in_valid <= 1'b1;
				in_sop   <= (i == 0);
				in_re    <= `FFT_DW'(fr_re[i]);
				in_im    <= `FFT_DW'(fr_im[i]);
			end
			@(posedge clk);
			if (in_valid && in_ready) begin
				if (i == 0)
					sop_cyc = cyc;
				if (i == `FFT_N - 1)
					full_cyc = cyc;
				i++;
			end
		end
		in_valid <= 1'b0;
		in_sop   <= 1'b0;
		frames_sent++;
	endtask

	task automatic wait_frames(input int target);
		int n;
		n = 0;
		while (frames_out < target && n < FRAME_WAIT) begin
			@(posedge clk);
			n++;
		end
		if (frames_out < target) begin
			errors++;
			$display("%s: output frame %0d did not complete within %0d cycles",
				cur_test, target, FRAME_WAIT);
		end
	endtask

	task automatic fill_random();
		int n;
		for (n = 0; n < `FFT_N; n++) begin
			fr_re[n] = draw_sample();
			fr_im[n] = draw_sample();
		end
	endtask

	// --------------------
	// Directed tests
	// --------------------
	task automatic probe_registers();
		logic [31:0] rd;
		logic        err;
		cur_test = "registers";
		expect_equal("out_valid after reset", 0, int'(out_valid));
		expect_equal("pready", 1, int'(pready));
		apb_read(`FFT_REG_CTRL, rd, err);
		expect_equal("CTRL after reset", 0, int'(rd));
		expect_equal("CTRL read pslverr", 0, int'(err));
		// Offered sop sample must not be accepted while disabled
		in_valid <= 1'b1;
		in_sop   <= 1'b1;
		repeat (4) begin
			@(posedge clk);
			expect_equal("in_ready while disabled", 0, int'(in_ready));
		end
		in_valid <= 1'b0;
		in_sop   <= 1'b0;
		apb_write(`FFT_REG_CTRL, 32'h0000_000f, err);
		apb_read(`FFT_REG_CTRL, rd, err);
		expect_equal("CTRL readback", 32'h0000_000f, int'(rd));
		// STATUS is read only
		apb_write(`FFT_REG_STATUS, 32'hffff_ffff, err);
		apb_read(`FFT_REG_STATUS, rd, err);
		expect_equal("STATUS after write", 0, int'(rd));
		apb_write(4'h8, 32'h0, err);
		expect_equal("unmapped write pslverr", 1, int'(err));
		apb_read(4'hc, rd, err);
		expect_equal("unmapped read pslverr", 1, int'(err));
		apb_read(`FFT_REG_CTRL, rd, err);
		expect_equal("CTRL after unmapped write", 32'h0000_000f, int'(rd));
		apb_write(`FFT_REG_CTRL, 32'h0, err);
	endtask

	task automatic impulse_frame();
		int sop_cyc;
		int full_cyc;
		int n;
		cur_test = "impulse";
		set_ctrl(3'b000);
		for (n = 0; n < `FFT_N; n++) begin
			fr_re[n] = (n == 0) ? 1000 : 0;
			fr_im[n] = 0;
		end
		push_reference(3'b000);
		send_frame(1'b0, sop_cyc, full_cyc);
		wait_frames(frames_sent);
		// Flat spectrum, exact
		compare_bins(0);
	endtask

	task automatic scaled_constant();
		int sop_cyc;
		int full_cyc;
		int n;
		cur_test = "scaling";
		set_ctrl(3'b111);
		for (n = 0; n < `FFT_N; n++) begin
			fr_re[n] = 800;
			fr_im[n] = 0;
		end
		push_reference(3'b111);
		send_frame(1'b0, sop_cyc, full_cyc);
		wait_frames(frames_sent);
		compare_bins(TOL);
	endtask

	task automatic random_frames();
		int         sop_cyc;
		int         full_cyc;
		int         f;
		logic [2:0] mask;
		cur_test = "random";
		for (f = 0; f < 4; f++) begin
			mask = 3'(draw_bits());
			set_ctrl(mask);
			fill_random();
			push_reference(mask);
			send_frame(1'b1, sop_cyc, full_cyc);
			wait_frames(frames_sent);
			compare_bins(TOL);
			// Completion is the cycle after the eighth sample
			expect_equal("first out_valid latency", LATENCY, first_valid_cyc - full_cyc - 1);
		end
	endtask

	task automatic backpressure_frames();
		logic [31:0] rd;
		logic        err;
		int          sop_a;
		int          full_a;
		int          sop_b;
		int          full_b;
		int          idx_a;
		cur_test = "backpressure";
		set_ctrl(3'b010);
		bp_en <= 1'b1;
		fill_random();
		push_reference(3'b010);
		send_frame(1'b0, sop_a, full_a);
		// Output frame number of the first one
		idx_a = frames_sent - 1;
		// Second frame offered at once, held off until the first one is out
		fill_random();
		push_reference(3'b010);
		send_frame(1'b0, sop_b, full_b);
		apb_read(`FFT_REG_STATUS, rd, err);
		expect_equal("STATUS busy while processing", 1, int'(rd[0]));
		wait_frames(frames_sent);
		compare_bins(TOL);
		checks++;
		if (eop_cycs.size() <= idx_a) begin
			errors++;
			$display("%s: first frame never completed on the output", cur_test);
		end else if (sop_b <= eop_cycs[idx_a]) begin
			errors++;
			$display("[ERROR] %s: second frame start cycle expected > %0d actual %0d",
				cur_test, eop_cycs[idx_a], sop_b);
		end
		bp_en <= 1'b0;
		apb_read(`FFT_REG_STATUS, rd, err);
		expect_equal("STATUS after last frame", (frames_sent % 256) << 8, int'(rd));
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		rst_n    <= 1'b0;
		psel     <= 1'b0;
		penable  <= 1'b0;
		pwrite   <= 1'b0;
		paddr    <= '0;
		pwdata   <= '0;
		in_valid <= 1'b0;
		in_sop   <= 1'b0;
		in_re    <= '0;
		in_im    <= '0;
		bp_en    <= 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		probe_registers();
		impulse_frame();
		scaled_constant();
		random_frames();
		backpressure_frames();
		repeat (4)
			@(posedge clk);
		$display("Checks: %0d, errors: %0d", checks + flag_checks, errors + flag_errors);
		if (errors + flag_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Bound on total run time
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
		$display("Regression failed");
		$finish;
	end
endmodule

// ==== src.f ====
+incdir+source
source/fft_pkg.sv
source/fft_bfly_if.sv
source/fft_apb_regs.sv
source/fft_sink.sv
source/fft_engine.sv
source/fft_bfly.sv
source/fft_source.sv
source/fft_top.sv
tests/fft_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the FFT subsystem with its testbench, run it and look for the pass line
verilator --binary --timing --assert -f src.f --top-module fft_tb -o fft_sim \
	&& ./obj_dir/fft_sim | tee /dev/stderr | grep -q "Regression passed" \
	&& echo "Simulation OK" \
	|| { echo "Simulation FAILED"; exit 1; }
